//--- hw/riscvPkg.sv
// RV32I definitions: data width, word type, opcodes and the U/J instruction union.
`default_nettype none

package riscvPkg;

  localparam int xlen = 32; // Data and address width.

  typedef logic [xlen-1:0] wordT; // One data or address word.

  localparam logic [6:0] opLui   = 7'b0110111; // Load upper immediate.
  localparam logic [6:0] opAuipc = 7'b0010111; // Add upper immediate to PC.
  localparam logic [6:0] opJal   = 7'b1101111; // Jump and link.

  // U-type layout, used by LUI and AUIPC.
  typedef struct packed {
    logic [19:0] imm31to12; // Upper immediate bits 31..12.
    logic [4:0]  rd;        // Destination register.
    logic [6:0]  opcode;    // Major opcode.
  } uFormT;

  // J-type layout, used by JAL. The offset bits are scrambled.
  typedef struct packed {
    logic        imm20;     // Sign bit of the offset.
    logic [9:0]  imm10to1;  // Offset bits 10..1.
    logic        imm11;     // Offset bit 11.
    logic [7:0]  imm19to12; // Offset bits 19..12.
    logic [4:0]  rd;        // Destination register.
    logic [6:0]  opcode;    // Major opcode.
  } jFormT;

  // The same fetched word, read either as U-type or as J-type.
  typedef union packed {
    uFormT uForm; // Upper immediate view.
    jFormT jForm; // Jump offset view.
  } instrT;

endpackage

`default_nettype wire

//--- hw/coreCfgPkg.sv
// Core configuration: fetch address after reset and sequential PC increment.
`default_nettype none

package coreCfgPkg;

  // First fetch address out of reset.
  localparam logic [31:0] resetPc = 32'h0000_1000;

  // Distance between sequential instructions, no compressed ISA.
  localparam logic [31:0] pcStep = 32'd4;

endpackage

`default_nettype wire

//--- hw/immDecode.sv
// Instruction classifier for JAL, LUI and AUIPC with U and J immediate extraction.
`default_nettype none

module immDecode (
  input  wire riscvPkg::instrT instr,   // Word in the rename stage.
  input  wire logic            instValid, // Strobe, word is valid this cycle.
  output logic                 isJal,   // Valid JAL.
  output logic                 isLui,   // Valid LUI.
  output logic                 isAuipc, // Valid AUIPC.
  output riscvPkg::wordT       immExt   // Extended immediate, zero when not valid.
);

  logic [6:0]     opcode; // Opcode field, same place in both views.
  riscvPkg::wordT immJ;   // Sign-extended jump offset.
  riscvPkg::wordT immU;   // Upper immediate with clear low bits.
  logic           opJal;  // Opcode match before gating.
  logic           opLui;
  logic           opAuipc;

  assign opcode  = instr.uForm.opcode;
  assign opJal   = (opcode == riscvPkg::opJal);
  assign opLui   = (opcode == riscvPkg::opLui);
  assign opAuipc = (opcode == riscvPkg::opAuipc);

  // Kind flags only count on a valid strobe.
  assign isJal   = instValid & opJal;
  assign isLui   = instValid & opLui;
  assign isAuipc = instValid & opAuipc;

  // Put the J offset back in order, bit 0 is always zero.
  assign immJ = {{11{instr.jForm.imm20}},
                 instr.jForm.imm20,
                 instr.jForm.imm19to12,
                 instr.jForm.imm11,
                 instr.jForm.imm10to1,
                 1'b0};

  // U immediate sits in the top 20 bits.
  assign immU = {instr.uForm.imm31to12, 12'd0};

  always_comb begin
    immExt = '0;                     // Nothing to extend.
    if (instValid) begin
      if (opJal) begin
        immExt = immJ;               // JAL offset.
      end else if (opLui | opAuipc) begin
        immExt = immU;               // LUI and AUIPC share the U form.
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/juUnit.sv
// Combinational jump unit: rd result for JAL, LUI and AUIPC, plus the JAL target.
`default_nettype none

module juUnit (
  input  wire riscvPkg::wordT pc,      // PC of the instruction.
  input  wire riscvPkg::wordT immExt,  // Extended immediate.
  input  wire logic           isJal,
  input  wire logic           isLui,
  input  wire logic           isAuipc,
  output riscvPkg::wordT      result,  // Value for rd.
  output riscvPkg::wordT      target   // Jump address, only JAL uses it.
);

  riscvPkg::wordT seqPc;   // Return address, next sequential PC.
  riscvPkg::wordT pcImm;   // Shared adder for AUIPC and JAL target.
  logic [2:0]     kind;    // One-hot kind.

  assign seqPc  = pc + coreCfgPkg::pcStep;
  assign pcImm  = pc + immExt;
  assign target = pcImm;                   // Fetch only loads it on JAL.
  assign kind   = {isJal, isAuipc, isLui};

  always_comb begin
    case (kind)
      3'b100:  result = seqPc;   // JAL links the return address.
      3'b010:  result = pcImm;   // AUIPC.
      3'b001:  result = immExt;  // LUI.
      default: result = '0;      // Not a JU instruction, never written back.
    endcase
  end

endmodule

`default_nettype wire

//--- hw/juWriteback.sv
// One-entry result register that offers the JU result on the CDB until it is granted.
`default_nettype none

module juWriteback #(
  parameter int robTagBits = 4 // ROB tag width.
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  isJal,
  input  wire logic                  isLui,
  input  wire logic                  isAuipc,
  input  wire riscvPkg::wordT        result,   // Computed rd value.
  input  wire logic [robTagBits-1:0] instTag,  // ROB entry of the instruction.
  input  wire logic                  cdbGrant, // Arbiter grant, a level.
  output logic                       cdbValid, // Offer on the CDB.
  output logic [robTagBits-1:0]      cdbTag,
  output riscvPkg::wordT             cdbData,
  output logic                       stall     // Holds the front end.
);

  logic                  pending;  // Entry holds an ungranted result.
  logic [robTagBits-1:0] tagReg;   // Stored ROB tag.
  riscvPkg::wordT        dataReg;  // Stored result.
  logic                  isJu;     // Any JU kind this cycle.
  logic                  load;     // Accept into the entry.

  assign isJu  = isJal | isLui | isAuipc;
  assign stall = pending & ~cdbGrant;  // Full and not leaving.
  assign load  = isJu & ~stall;        // Grant frees the slot this same clock.

  // Valid bit of the entry.
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (load) begin
      pending <= 1'b1;                 // New result, or back-to-back after grant.
    end else if (cdbGrant) begin
      pending <= 1'b0;                 // Granted and nothing new.
    end
  end

  // Payload only moves on an accepted instruction.
  always_ff @(posedge clk) begin
    if (load) begin
      tagReg  <= instTag;
      dataReg <= result;
    end
  end

  assign cdbValid = pending;
  assign cdbTag   = tagReg;
  assign cdbData  = dataReg;

endmodule

`default_nettype wire

//--- hw/fetchRedirect.sv
// Fetch PC register with sequential advance, JAL redirect and stall hold.
`default_nettype none

module fetchRedirect (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           stall,   // Back-pressure from writeback.
  input  wire logic           isJal,   // Accepted JAL this cycle.
  input  wire riscvPkg::wordT target,  // Jump address from the unit.
  output riscvPkg::wordT      fetchPc  // Address sent to fetch.
);

  riscvPkg::wordT pcReg;   // Current fetch address.
  riscvPkg::wordT pcNext;  // Address for the next clock.

  always_comb begin
    if (stall) begin
      pcNext = pcReg;                        // Front end frozen.
    end else if (isJal) begin
      pcNext = target;                       // Redirect to the jump target.
    end else begin
      pcNext = pcReg + coreCfgPkg::pcStep;   // Sequential fetch.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pcReg <= coreCfgPkg::resetPc;
    end else begin
      pcReg <= pcNext;
    end
  end

  assign fetchPc = pcReg;

endmodule

`default_nettype wire

//--- hw/juTop.sv
// JU path top: decode, compute, writeback and fetch redirect.
`default_nettype none

module juTop #(
  parameter int robTagBits = 4 // ROB tag width, passed to writeback.
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  instValid, // Rename-stage strobe.
  input  wire riscvPkg::instrT       instr,
  input  wire riscvPkg::wordT        instPc,
  input  wire logic [robTagBits-1:0] instTag,
  input  wire logic                  cdbGrant,
  output logic                       cdbValid,
  output logic [robTagBits-1:0]      cdbTag,
  output riscvPkg::wordT             cdbData,
  output riscvPkg::wordT             fetchPc,
  output logic                       stall
);

  logic           isJal;   // Decoded kinds.
  logic           isLui;
  logic           isAuipc;
  riscvPkg::wordT immExt;  // Immediate into the unit.
  riscvPkg::wordT result;  // Value for rd.
  riscvPkg::wordT target;  // JAL destination.

  immDecode uDecode (
    .instr     (instr),
    .instValid (instValid),
    .isJal     (isJal),
    .isLui     (isLui),
    .isAuipc   (isAuipc),
    .immExt    (immExt)
  );

  juUnit uUnit (
    .pc      (instPc),
    .immExt  (immExt),
    .isJal   (isJal),
    .isLui   (isLui),
    .isAuipc (isAuipc),
    .result  (result),
    .target  (target)
  );

  juWriteback #(
    .robTagBits (robTagBits)
  ) uWriteback (
    .clk      (clk),
    .rst      (rst),
    .isJal    (isJal),
    .isLui    (isLui),
    .isAuipc  (isAuipc),
    .result   (result),
    .instTag  (instTag),
    .cdbGrant (cdbGrant),
    .cdbValid (cdbValid),
    .cdbTag   (cdbTag),
    .cdbData  (cdbData),
    .stall    (stall)
  );

  // A stalled JAL is not accepted, so it must not redirect.
  fetchRedirect uRedirect (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .isJal   (isJal & ~stall),
    .target  (target),
    .fetchPc (fetchPc)
  );

endmodule

`default_nettype wire

//--- test/juTb.sv
// Testbench for juTop: clock, reset, watchdog, compare tasks and directed JU tests.
`default_nettype none

module juTb;

  localparam int tagBits   = 4;   // ROB tag width under test.
  localparam int numTests  = 6;   // Directed tests in the run.
  localparam int maxWait   = 8;   // Cycles allowed for cdbValid to rise.
  localparam int holdCycles = 4;  // Cycles of held-off grant.

  logic                clk = 1'b0;
  logic                rst;
  logic                instValid;
  riscvPkg::instrT     instr;
  riscvPkg::wordT      instPc;
  logic [tagBits-1:0]  instTag;
  logic                cdbGrant;
  logic                cdbValid;
  logic [tagBits-1:0]  cdbTag;
  riscvPkg::wordT      cdbData;
  riscvPkg::wordT      fetchPc;
  logic                stall;

  int             errorCount = 0;   // Failed checks so far.
  int             checkCount = 0;   // Checks made so far.
  int             testsRun   = 0;
  logic [31:0]    lcgState   = 32'hf02;
  riscvPkg::wordT pcExp;            // Reference fetch address.

  juTop #(
    .robTagBits (tagBits)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .instr     (instr),
    .instPc    (instPc),
    .instTag   (instTag),
    .cdbGrant  (cdbGrant),
    .cdbValid  (cdbValid),
    .cdbTag    (cdbTag),
    .cdbData   (cdbData),
    .fetchPc   (fetchPc),
    .stall     (stall)
  );

  always #5 clk = ~clk; // Period 10.

  // Hard stop if a test hangs.
  initial begin
    #((numTests * 40 + 50) * 10);
    $display("Timeout: the tests did not finish within the cycle budget.");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223; // Numerical Recipes LCG.
    return lcgState;
  endfunction

  function automatic riscvPkg::wordT randPc();
    logic [31:0] r;
    r = nextRand();
    return {r[31:2], 2'b00}; // Word aligned.
  endfunction

  task automatic checkWord(input string name, input riscvPkg::wordT expected,
                           input riscvPkg::wordT actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkTag(input string name, input logic [tagBits-1:0] expected,
                          input logic [tagBits-1:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testsRun++;
    $display("Test %s done, %0d errors.", name, errorCount - errorsBefore);
  endtask

  // Grant the pending result and expect the CDB to empty.
  task automatic releaseCdb();
    cdbGrant = 1'b1;
    @(negedge clk);
    cdbGrant = 1'b0;
    pcExp    = pcExp + coreCfgPkg::pcStep; // Grant clock is not stalled.
    checkBit("cdbValid", 1'b0, cdbValid);
    checkBit("stall", 1'b0, stall);
    checkWord("fetchPc", pcExp, fetchPc);
  endtask

  // Issue one JU instruction, wait for the CDB offer and check it.
  task automatic runJu(input riscvPkg::instrT word, input riscvPkg::wordT pc,
                       input logic [tagBits-1:0] tag, input riscvPkg::wordT expData,
                       input riscvPkg::wordT expPc);
    int cycles;
    checkBit("stall", 1'b0, stall);
    instr     = word;
    instPc    = pc;
    instTag   = tag;
    instValid = 1'b1;
    @(negedge clk);
    instValid = 1'b0;       // One-cycle strobe.
    cycles = 1;
    while (!cdbValid && cycles < maxWait) begin
      @(negedge clk);
      cycles++;
    end
    checkCount++;
    if (!cdbValid) begin
      errorCount++;
      $display("Error at t=%0t: cdbValid never rose within %0d cycles.", $time, maxWait);
    end else if (cycles != 1) begin
      errorCount++;
      $display("Error at t=%0t: cdbValid rose after %0d cycles, not 1.", $time, cycles);
    end
    checkTag("cdbTag", tag, cdbTag);
    checkWord("cdbData", expData, cdbData);
    checkWord("fetchPc", expPc, fetchPc);
    pcExp = expPc;
    releaseCdb();
  endtask

  task automatic testReset();
    int errorsBefore;
    errorsBefore = errorCount;
    pcExp        = coreCfgPkg::resetPc;
    checkBit("cdbValid", 1'b0, cdbValid);
    checkBit("stall", 1'b0, stall);
    checkWord("fetchPc", pcExp, fetchPc);
    finishTest("reset", errorsBefore);
  endtask

  task automatic testLui();
    int             errorsBefore;
    logic [31:0]    r;
    riscvPkg::wordT pc;
    errorsBefore = errorCount;
    for (int i = 0; i < 8; i++) begin
      r  = nextRand();
      pc = randPc();
      runJu({r[31:12], r[11:7], riscvPkg::opLui}, pc, r[tagBits-1:0],
            {r[31:12], 12'h000}, pcExp + coreCfgPkg::pcStep);
    end
    finishTest("LUI", errorsBefore);
  endtask

  task automatic testAuipc();
    int             errorsBefore;
    logic [31:0]    r;
    riscvPkg::wordT pc;
    errorsBefore = errorCount;
    for (int i = 0; i < 8; i++) begin
      r  = nextRand();
      pc = randPc();
      runJu({r[31:12], r[11:7], riscvPkg::opAuipc}, pc, r[tagBits-1:0],
            pc + {r[31:12], 12'h000}, pcExp + coreCfgPkg::pcStep);
    end
    finishTest("AUIPC", errorsBefore);
  endtask

  task automatic testJal();
    int             errorsBefore;
    logic [31:0]    r;
    logic [20:0]    off;     // Byte offset, bit 0 always zero.
    riscvPkg::wordT offExt;
    riscvPkg::wordT pc;
    errorsBefore = errorCount;
    for (int i = 0; i < 8; i++) begin
      r   = nextRand();
      pc  = randPc();
      off = {r[20:1], 1'b0};
      if (i % 2 == 0) begin
        off[20] = 1'b1;      // Backward jump.
      end
      offExt = {{11{off[20]}}, off};
      runJu({off[20], off[10:1], off[11], off[19:12], r[25:21], riscvPkg::opJal}, pc,
            r[tagBits+7:8], pc + coreCfgPkg::pcStep, pc + offExt);
    end
    finishTest("JAL", errorsBefore);
  endtask

  task automatic testBackpressure();
    int                 errorsBefore;
    logic [31:0]        r;
    logic [20:0]        off;
    riscvPkg::wordT     immA;
    riscvPkg::wordT     pcB;
    riscvPkg::wordT     offExt;
    logic [tagBits-1:0] tagA;
    logic [tagBits-1:0] tagB;
    riscvPkg::instrT    wordB;
    errorsBefore = errorCount;
    r      = nextRand();
    immA   = {r[31:12], 12'h000};
    tagA   = r[tagBits-1:0];
    tagB   = tagA + 1'b1;
    instr  = {r[31:12], 5'd3, riscvPkg::opLui};
    instPc = randPc();
    r      = nextRand();
    off    = {1'b1, r[19:1], 1'b0};
    offExt = {{11{off[20]}}, off};
    wordB  = {off[20], off[10:1], off[11], off[19:12], 5'd1, riscvPkg::opJal};
    pcB    = randPc();
    instTag   = tagA;
    instValid = 1'b1;         // LUI is accepted.
    @(negedge clk);
    instr   = wordB;          // JAL waits behind it.
    instPc  = pcB;
    instTag = tagB;
    pcExp   = pcExp + coreCfgPkg::pcStep;
    checkBit("cdbValid", 1'b1, cdbValid);
    checkBit("stall", 1'b1, stall);
    checkWord("fetchPc", pcExp, fetchPc);
    repeat (holdCycles) begin
      @(negedge clk);
      checkBit("cdbValid", 1'b1, cdbValid);
      checkBit("stall", 1'b1, stall);
      checkTag("cdbTag", tagA, cdbTag);
      checkWord("cdbData", immA, cdbData);
      checkWord("fetchPc", pcExp, fetchPc);
    end
    cdbGrant = 1'b1;          // LUI leaves, JAL enters on the same clock.
    @(negedge clk);
    cdbGrant  = 1'b0;
    instValid = 1'b0;
    pcExp     = pcB + offExt;
    checkBit("cdbValid", 1'b1, cdbValid);
    checkTag("cdbTag", tagB, cdbTag);
    checkWord("cdbData", pcB + coreCfgPkg::pcStep, cdbData);
    checkWord("fetchPc", pcExp, fetchPc);
    releaseCdb();
    finishTest("back-pressure", errorsBefore);
  endtask

  task automatic testNonJu();
    int             errorsBefore;
    logic [31:0]    r;
    errorsBefore = errorCount;
    for (int i = 0; i < 3; i++) begin
      r         = nextRand();
      instr     = {r[31:7], 7'b0110011};    // ADD class opcode.
      instPc    = randPc();
      instValid = 1'b1;
      @(negedge clk);
      instValid = 1'b0;
      pcExp     = pcExp + coreCfgPkg::pcStep;
      checkBit("cdbValid", 1'b0, cdbValid);
      checkBit("stall", 1'b0, stall);
      checkWord("fetchPc", pcExp, fetchPc);
      instr = {r[31:7], riscvPkg::opJal};   // JAL word without the strobe.
      @(negedge clk);
      pcExp = pcExp + coreCfgPkg::pcStep;
      checkBit("cdbValid", 1'b0, cdbValid);
      checkWord("fetchPc", pcExp, fetchPc);
    end
    finishTest("non-JU", errorsBefore);
  endtask

  initial begin
    rst       = 1'b1;
    instValid = 1'b0;
    instr     = '0;
    instPc    = '0;
    instTag   = '0;
    cdbGrant  = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testReset();
    testLui();
    testAuipc();
    testJal();
    testBackpressure();
    testNonJu();
    $display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/riscvPkg.sv
hw/coreCfgPkg.sv
hw/immDecode.sv
hw/juUnit.sv
hw/juWriteback.sv
hw/fetchRedirect.sv
hw/juTop.sv
test/juTb.sv

//--- Makefile
# Verilator build and run for the JU path testbench.

VERILATOR ?= verilator
TOP       ?= juTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0
PASSTEXT  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output.
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)
